// ==== src/rv32_types.sv ====
// Shared word types, CSR address and op enums, bus structs and CSR field positions
package rv32_types;

    typedef logic [31:0] rv32_word;

    // Index 0 is the low half, index 1 the high half
    typedef logic [1:0][31:0] rv64_word;

    typedef enum logic [11:0] {
        CSR_MSTATUS       = 12'h300,
        CSR_MIE           = 12'h304,
        CSR_MTVEC         = 12'h305,
        CSR_MCOUNTINHIBIT = 12'h320,
        CSR_MSCRATCH      = 12'h340,
        CSR_MEPC          = 12'h341,
        CSR_MCAUSE        = 12'h342,
        CSR_MCYCLE        = 12'hB00,
        CSR_MINSTRET      = 12'hB02,
        CSR_MCYCLEH       = 12'hB80,
        CSR_MINSTRETH     = 12'hB82
    } csr_addr_t;

    // Same encoding as funct3[1:0] of CSRRW, CSRRS and CSRRC
    typedef enum logic [1:0] {
        CSR_OP_WRITE = 2'b01,
        CSR_OP_SET   = 2'b10,
        CSR_OP_CLEAR = 2'b11
    } csr_op_t;

    typedef struct packed {
        logic      strobe;
        csr_op_t   op;
        csr_addr_t addr;
        rv32_word  operand;
    } csr_request_t;

    typedef struct packed {
        logic     strobe;
        rv32_word data;
        logic     illegal;
    } csr_response_t;

    typedef struct packed {
        logic      we;
        csr_addr_t addr;
        rv32_word  value;
    } csr_write_t;

    typedef struct packed {
        logic     enter;
        logic     mret;
        rv32_word pc;
        rv32_word cause;
    } trap_update_t;

    typedef struct packed {
        logic mpie;
        logic mie;
    } mstatus_t;

    typedef struct packed {
        logic meie;
        logic mtie;
        logic msie;
    } mie_t;

    typedef struct packed {
        logic external;
        logic timer;
        logic software;
    } irq_lines_t;

    typedef struct packed {
        logic     strobe;
        rv32_word pc;
    } retire_t;

    // Bit positions inside the architectural registers
    localparam int unsigned MSTATUS_MIE_POS  = 3;
    localparam int unsigned MSTATUS_MPIE_POS = 7;
    localparam int unsigned MIE_MSIE_POS     = 3;
    localparam int unsigned MIE_MTIE_POS     = 7;
    localparam int unsigned MIE_MEIE_POS     = 11;
    localparam int unsigned INHIBIT_CY_POS   = 0;
    localparam int unsigned INHIBIT_IR_POS   = 2;

    // Interrupt cause codes, flag goes in bit 31 of mcause
    localparam int unsigned CAUSE_MSI           = 3;
    localparam int unsigned CAUSE_MTI           = 7;
    localparam int unsigned CAUSE_MEI           = 11;
    localparam int unsigned CAUSE_INTERRUPT_POS = 31;

endpackage

// ==== src/csr_rmw_unit.sv ====
// Read-modify-write value computation for CSRRW, CSRRS and CSRRC
`timescale 1ns/1ps

module csr_rmw_unit (
    input  rv32_types::csr_op_t  op,
    input  rv32_types::rv32_word operand,
    input  rv32_types::rv32_word old_value,
    output rv32_types::rv32_word new_value,
    output logic                 changes
);

    always_comb begin
        new_value = old_value;
        changes   = 1'b0;
        case (op)
            rv32_types::CSR_OP_WRITE: begin
                new_value = operand;
                changes   = 1'b1;
            end
            rv32_types::CSR_OP_SET: begin
                new_value = old_value | operand;
                // A zero mask means a pure read
                changes   = |operand;
            end
            rv32_types::CSR_OP_CLEAR: begin
                new_value = old_value & ~operand;
                changes   = |operand;
            end
            default: begin
                new_value = old_value;
                changes   = 1'b0;
            end
        endcase
    end

endmodule

// ==== src/csr_counters.sv ====
// mcycle and minstret counters with mcountinhibit and 32-bit half writes
`timescale 1ns/1ps

module csr_counters #(
    parameter int unsigned COUNTER_WIDTH = 64
) (
    input  logic                   clk,
    input  logic                   resetn,
    input  rv32_types::csr_write_t csr_write,
    input  logic                   instr_retired,
    output rv32_types::rv64_word   mcycle,
    output rv32_types::rv64_word   minstret,
    output rv32_types::rv32_word   inhibit_value
);

    logic                     inhibit_cy;
    logic                     inhibit_ir;
    logic                     inhibit_cy_next;
    logic                     inhibit_ir_next;
    logic [COUNTER_WIDTH-1:0] cycle_q;
    logic [COUNTER_WIDTH-1:0] instret_q;
    rv32_types::rv64_word     cycle_next;
    rv32_types::rv64_word     instret_next;

    always_comb begin
        inhibit_cy_next = inhibit_cy;
        inhibit_ir_next = inhibit_ir;
        cycle_next      = 64'(cycle_q);
        instret_next    = 64'(instret_q);

        // Free counting
        if (!inhibit_cy) begin
            cycle_next = 64'(cycle_q + 1'b1);
        end
        if (!inhibit_ir && instr_retired) begin
            instret_next = 64'(instret_q + 1'b1);
        end

        // Software write overrides the count for the written half only
        if (csr_write.we) begin
            case (csr_write.addr)
                rv32_types::CSR_MCOUNTINHIBIT: begin
                    inhibit_cy_next = csr_write.value[rv32_types::INHIBIT_CY_POS];
                    inhibit_ir_next = csr_write.value[rv32_types::INHIBIT_IR_POS];
                end
                rv32_types::CSR_MCYCLE:    cycle_next[0]   = csr_write.value;
                rv32_types::CSR_MCYCLEH:   cycle_next[1]   = csr_write.value;
                rv32_types::CSR_MINSTRET:  instret_next[0] = csr_write.value;
                rv32_types::CSR_MINSTRETH: instret_next[1] = csr_write.value;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            inhibit_cy <= 1'b0;
            inhibit_ir <= 1'b0;
            cycle_q    <= '0;
            instret_q  <= '0;
        end else begin
            inhibit_cy <= inhibit_cy_next;
            inhibit_ir <= inhibit_ir_next;
            cycle_q    <= COUNTER_WIDTH'(cycle_next);
            instret_q  <= COUNTER_WIDTH'(instret_next);
        end
    end

    assign mcycle   = 64'(cycle_q);
    assign minstret = 64'(instret_q);

    always_comb begin
        inhibit_value = '0;
        inhibit_value[rv32_types::INHIBIT_CY_POS] = inhibit_cy;
        inhibit_value[rv32_types::INHIBIT_IR_POS] = inhibit_ir;
    end

endmodule

// ==== src/rv32_csr.sv ====
// Machine-mode CSR bank with read mux, software writes and trap or mret updates
`timescale 1ns/1ps

module rv32_csr (
    input  logic                     clk,
    input  logic                     resetn,
    input  rv32_types::csr_addr_t    read_addr,
    input  rv32_types::csr_write_t   csr_write,
    input  rv32_types::trap_update_t trap_update,
    input  rv32_types::rv64_word     mcycle,
    input  rv32_types::rv64_word     minstret,
    input  rv32_types::rv32_word     inhibit_value,
    output rv32_types::rv32_word     read_value,
    output logic                     illegal,
    output rv32_types::mstatus_t     mstatus,
    output rv32_types::mie_t         mie,
    output rv32_types::rv32_word     mtvec,
    output rv32_types::rv32_word     mepc
);

    rv32_types::rv32_word mcause;
    rv32_types::rv32_word mscratch;

    rv32_types::mstatus_t mstatus_next;
    rv32_types::mie_t     mie_next;
    rv32_types::rv32_word mtvec_next;
    rv32_types::rv32_word mepc_next;
    rv32_types::rv32_word mcause_next;
    rv32_types::rv32_word mscratch_next;

    // Read mux, unknown addresses read as zero
    always_comb begin
        read_value = '0;
        illegal    = 1'b0;
        case (read_addr)
            rv32_types::CSR_MSTATUS: begin
                read_value[rv32_types::MSTATUS_MIE_POS]  = mstatus.mie;
                read_value[rv32_types::MSTATUS_MPIE_POS] = mstatus.mpie;
            end
            rv32_types::CSR_MIE: begin
                read_value[rv32_types::MIE_MSIE_POS] = mie.msie;
                read_value[rv32_types::MIE_MTIE_POS] = mie.mtie;
                read_value[rv32_types::MIE_MEIE_POS] = mie.meie;
            end
            rv32_types::CSR_MTVEC:         read_value = mtvec;
            rv32_types::CSR_MEPC:          read_value = mepc;
            rv32_types::CSR_MCAUSE:        read_value = mcause;
            rv32_types::CSR_MSCRATCH:      read_value = mscratch;
            rv32_types::CSR_MCOUNTINHIBIT: read_value = inhibit_value;
            rv32_types::CSR_MCYCLE:        read_value = mcycle[0];
            rv32_types::CSR_MCYCLEH:       read_value = mcycle[1];
            rv32_types::CSR_MINSTRET:      read_value = minstret[0];
            rv32_types::CSR_MINSTRETH:     read_value = minstret[1];
            default: begin
                read_value = '0;
                illegal    = 1'b1;
            end
        endcase
    end

    always_comb begin
        mstatus_next  = mstatus;
        mie_next      = mie;
        mtvec_next    = mtvec;
        mepc_next     = mepc;
        mcause_next   = mcause;
        mscratch_next = mscratch;

        // Software write first, counter addresses belong to csr_counters
        if (csr_write.we) begin
            case (csr_write.addr)
                rv32_types::CSR_MSTATUS: begin
                    mstatus_next.mie  = csr_write.value[rv32_types::MSTATUS_MIE_POS];
                    mstatus_next.mpie = csr_write.value[rv32_types::MSTATUS_MPIE_POS];
                end
                rv32_types::CSR_MIE: begin
                    mie_next.msie = csr_write.value[rv32_types::MIE_MSIE_POS];
                    mie_next.mtie = csr_write.value[rv32_types::MIE_MTIE_POS];
                    mie_next.meie = csr_write.value[rv32_types::MIE_MEIE_POS];
                end
                rv32_types::CSR_MTVEC:    mtvec_next    = csr_write.value;
                rv32_types::CSR_MEPC:     mepc_next     = csr_write.value;
                rv32_types::CSR_MCAUSE:   mcause_next   = csr_write.value;
                rv32_types::CSR_MSCRATCH: mscratch_next = csr_write.value;
                default: ;
            endcase
        end

        // Trap entry stacks mie into mpie
        if (trap_update.enter) begin
            mepc_next         = trap_update.pc;
            mcause_next       = trap_update.cause;
            mstatus_next.mpie = mstatus_next.mie;
            mstatus_next.mie  = 1'b0;
        end

        // Return pops it back
        if (trap_update.mret) begin
            mstatus_next.mie  = mstatus_next.mpie;
            mstatus_next.mpie = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            mstatus  <= '{mpie: 1'b1, mie: 1'b0};
            mie      <= '0;
            mtvec    <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mscratch <= '0;
        end else begin
            mstatus  <= mstatus_next;
            mie      <= mie_next;
            mtvec    <= mtvec_next;
            mepc     <= mepc_next;
            mcause   <= mcause_next;
            mscratch <= mscratch_next;
        end
    end

    // Controller must never enter a trap and return in the same cycle
    enter_mret_exclusive: assert property (
        @(posedge clk) disable iff (!resetn)
        !(trap_update.enter && trap_update.mret)
    ) else $error("trap entry and mret requested together");

endmodule

// ==== src/trap_controller.sv ====
// Request sequencing, interrupt priority, trap entry, mret and response strobes
`timescale 1ns/1ps

module trap_controller (
    input  logic                      clk,
    input  logic                      resetn,
    input  rv32_types::csr_request_t  csr_req,
    input  rv32_types::retire_t       retire,
    input  logic                      mret,
    input  rv32_types::irq_lines_t    irq,
    input  rv32_types::rv32_word      old_value,
    input  logic                      illegal,
    input  rv32_types::rv32_word      rmw_value,
    input  logic                      rmw_changes,
    input  rv32_types::mstatus_t      mstatus_q,
    input  rv32_types::mie_t          mie_q,
    input  rv32_types::rv32_word      mtvec,
    input  rv32_types::rv32_word      mepc,
    output rv32_types::csr_write_t    csr_write,
    output rv32_types::trap_update_t  trap_update,
    output rv32_types::csr_response_t csr_rsp,
    output logic                      trap_taken,
    output logic                      mret_done,
    output rv32_types::rv32_word      target_pc
);

    logic                 ext_pending;
    logic                 sw_pending;
    logic                 timer_pending;
    logic                 take_trap;
    rv32_types::rv32_word irq_cause;
    logic                 rsp_strobe_q;
    rv32_types::rv32_word rsp_data_q;
    logic                 rsp_illegal_q;

    // Write only when the op changes something and the address exists
    assign csr_write = '{
        we:    csr_req.strobe && rmw_changes && !illegal,
        addr:  csr_req.addr,
        value: rmw_value
    };

    assign ext_pending   = irq.external && mie_q.meie;
    assign sw_pending    = irq.software && mie_q.msie;
    assign timer_pending = irq.timer && mie_q.mtie;
    assign take_trap     = retire.strobe && mstatus_q.mie
                           && (ext_pending || sw_pending || timer_pending);

    // External beats software beats timer
    always_comb begin
        irq_cause = '0;
        if (ext_pending) begin
            irq_cause = rv32_types::rv32_word'(rv32_types::CAUSE_MEI);
        end else if (sw_pending) begin
            irq_cause = rv32_types::rv32_word'(rv32_types::CAUSE_MSI);
        end else if (timer_pending) begin
            irq_cause = rv32_types::rv32_word'(rv32_types::CAUSE_MTI);
        end
        irq_cause[rv32_types::CAUSE_INTERRUPT_POS] = 1'b1;
    end

    assign trap_update = '{enter: take_trap, mret: mret, pc: retire.pc, cause: irq_cause};

    always_ff @(posedge clk) begin
        if (!resetn) begin
            rsp_strobe_q <= 1'b0;
            trap_taken   <= 1'b0;
            mret_done    <= 1'b0;
        end else begin
            rsp_strobe_q <= csr_req.strobe;
            trap_taken   <= take_trap;
            mret_done    <= mret;
        end
    end

    // Response carries the value seen before the write
    always_ff @(posedge clk) begin
        rsp_data_q    <= old_value;
        rsp_illegal_q <= illegal;
        if (take_trap) begin
            target_pc <= {mtvec[31:2], 2'b00};
        end else if (mret) begin
            target_pc <= mepc;
        end
    end

    assign csr_rsp = '{strobe: rsp_strobe_q, data: rsp_data_q, illegal: rsp_illegal_q};

    // Environment contract, CSR access never shares a cycle with retire or mret
    req_exclusive: assert property (
        @(posedge clk) disable iff (!resetn)
        csr_req.strobe |-> !(retire.strobe || mret)
    ) else $error("csr_req together with retire or mret");

    trap_mret_exclusive: assert property (
        @(posedge clk) disable iff (!resetn)
        !(trap_taken && mret_done)
    ) else $error("trap_taken and mret_done high together");

endmodule

// ==== src/csr_unit_top.sv ====
// Top level of the CSR and trap subsystem, wiring controller, bank, counters and RMW unit
`timescale 1ns/1ps

module csr_unit_top #(
    parameter int unsigned COUNTER_WIDTH = 64
) (
    input  logic                      clk,
    input  logic                      resetn,
    input  rv32_types::csr_request_t  csr_req,
    input  rv32_types::retire_t       retire,
    input  logic                      mret,
    input  rv32_types::irq_lines_t    irq,
    output rv32_types::csr_response_t csr_rsp,
    output logic                      trap_taken,
    output logic                      mret_done,
    output rv32_types::rv32_word      target_pc,
    output rv32_types::mstatus_t      mstatus
);

    rv32_types::csr_write_t   csr_write;
    rv32_types::trap_update_t trap_update;
    rv32_types::rv32_word     read_value;
    logic                     illegal;
    rv32_types::rv32_word     rmw_value;
    logic                     rmw_changes;
    rv32_types::mie_t         mie;
    rv32_types::rv32_word     mtvec;
    rv32_types::rv32_word     mepc;
    rv32_types::rv64_word     mcycle;
    rv32_types::rv64_word     minstret;
    rv32_types::rv32_word     inhibit_value;

    trap_controller trap_controller_i (
        .clk         (clk),
        .resetn      (resetn),
        .csr_req     (csr_req),
        .retire      (retire),
        .mret        (mret),
        .irq         (irq),
        .old_value   (read_value),
        .illegal     (illegal),
        .rmw_value   (rmw_value),
        .rmw_changes (rmw_changes),
        .mstatus_q   (mstatus),
        .mie_q       (mie),
        .mtvec       (mtvec),
        .mepc        (mepc),
        .csr_write   (csr_write),
        .trap_update (trap_update),
        .csr_rsp     (csr_rsp),
        .trap_taken  (trap_taken),
        .mret_done   (mret_done),
        .target_pc   (target_pc)
    );

    rv32_csr rv32_csr_i (
        .clk           (clk),
        .resetn        (resetn),
        .read_addr     (csr_req.addr),
        .csr_write     (csr_write),
        .trap_update   (trap_update),
        .mcycle        (mcycle),
        .minstret      (minstret),
        .inhibit_value (inhibit_value),
        .read_value    (read_value),
        .illegal       (illegal),
        .mstatus       (mstatus),
        .mie           (mie),
        .mtvec         (mtvec),
        .mepc          (mepc)
    );

    csr_counters #(
        .COUNTER_WIDTH (COUNTER_WIDTH)
    ) csr_counters_i (
        .clk           (clk),
        .resetn        (resetn),
        .csr_write     (csr_write),
        .instr_retired (retire.strobe),
        .mcycle        (mcycle),
        .minstret      (minstret),
        .inhibit_value (inhibit_value)
    );

    csr_rmw_unit csr_rmw_unit_i (
        .op        (csr_req.op),
        .operand   (csr_req.operand),
        .old_value (read_value),
        .new_value (rmw_value),
        .changes   (rmw_changes)
    );

endmodule

// ==== testbench/tb_csr_tasks.svh ====
// Driver tasks, typed compare tasks and directed tests for the CSR unit testbench

task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("STATUS: FAIL");
    $fatal(1, "Simulation stopped at first error");
endtask

function automatic rv32_types::csr_response_t rsp_of(input rv32_types::rv32_word data,
                                                    input logic illegal);
    rv32_types::csr_response_t rsp;
    rsp.strobe  = 1'b1;
    rsp.data    = data;
    rsp.illegal = illegal;
    return rsp;
endfunction

function automatic rv32_types::mstatus_t status_of(input logic mpie, input logic mie);
    rv32_types::mstatus_t st;
    st.mpie = mpie;
    st.mie  = mie;
    return st;
endfunction

// Architectural bit layouts as software sees them
function automatic rv32_types::rv32_word status_bits(input logic mpie, input logic mie);
    rv32_types::rv32_word w;
    w = '0;
    w[rv32_types::MSTATUS_MPIE_POS] = mpie;
    w[rv32_types::MSTATUS_MIE_POS]  = mie;
    return w;
endfunction

function automatic rv32_types::rv32_word enable_bits(input logic msie, input logic mtie,
                                                     input logic meie);
    rv32_types::rv32_word w;
    w = '0;
    w[rv32_types::MIE_MSIE_POS] = msie;
    w[rv32_types::MIE_MTIE_POS] = mtie;
    w[rv32_types::MIE_MEIE_POS] = meie;
    return w;
endfunction

function automatic rv32_types::rv32_word inhibit_bits(input logic cy, input logic ir);
    rv32_types::rv32_word w;
    w = '0;
    w[rv32_types::INHIBIT_CY_POS] = cy;
    w[rv32_types::INHIBIT_IR_POS] = ir;
    return w;
endfunction

task automatic check_word(input string name, input rv32_types::rv32_word got,
                          input rv32_types::rv32_word exp);
    checks_done++;
    if (got !== exp) begin
        abort_run($sformatf("[FAIL] %0t %s got %h expected %h", $time, name, got, exp));
    end
endtask

task automatic check_rsp(input string name, input rv32_types::csr_response_t got,
                         input rv32_types::csr_response_t exp);
    string got_text;
    string exp_text;
    checks_done++;
    if (got !== exp) begin
        got_text = $sformatf("strobe %b data %h illegal %b", got.strobe, got.data, got.illegal);
        exp_text = $sformatf("strobe %b data %h illegal %b", exp.strobe, exp.data, exp.illegal);
        abort_run($sformatf("[FAIL] %0t %s got %s expected %s",
                            $time, name, got_text, exp_text));
    end
endtask

task automatic check_status(input string name, input rv32_types::mstatus_t got,
                            input rv32_types::mstatus_t exp);
    checks_done++;
    if (got !== exp) begin
        abort_run($sformatf("[FAIL] %0t %s got mpie %b mie %b expected mpie %b mie %b",
                            $time, name, got.mpie, got.mie, exp.mpie, exp.mie));
    end
endtask

// Starts on a falling edge and returns on the one where the response is valid
task automatic csr_access(input rv32_types::csr_op_t op, input rv32_types::csr_addr_t addr,
                          input rv32_types::rv32_word operand,
                          output rv32_types::csr_response_t rsp);
    csr_req = '{strobe: 1'b1, op: op, addr: addr, operand: operand};
    @(posedge clk);
    @(negedge clk);
    rsp = csr_rsp;
    csr_req.strobe = 1'b0;
endtask

task automatic modify_csr(input rv32_types::csr_op_t op, input rv32_types::csr_addr_t addr,
                          input rv32_types::rv32_word operand,
                          input rv32_types::rv32_word exp_old);
    rv32_types::csr_response_t rsp;
    csr_access(op, addr, operand, rsp);
    check_rsp($sformatf("csr_rsp[%h]", addr), rsp, rsp_of(exp_old, 1'b0));
endtask

// Set with a zero mask reads without writing
task automatic expect_csr(input rv32_types::csr_addr_t addr, input rv32_types::rv32_word exp);
    modify_csr(rv32_types::CSR_OP_SET, addr, '0, exp);
endtask

task automatic do_retire(input rv32_types::rv32_word pc, output logic taken,
                         output rv32_types::rv32_word tpc);
    retire = '{strobe: 1'b1, pc: pc};
    @(posedge clk);
    @(negedge clk);
    taken = trap_taken;
    tpc   = target_pc;
    retire.strobe = 1'b0;
endtask

task automatic do_mret(output logic done, output rv32_types::rv32_word tpc);
    mret = 1'b1;
    @(posedge clk);
    @(negedge clk);
    done = mret_done;
    tpc  = target_pc;
    mret = 1'b0;
endtask

task automatic reset_and_plain_regs();
    rv32_types::rv32_word value;
    check_status("mstatus", mstatus, status_of(1'b1, 1'b0));
    expect_csr(rv32_types::CSR_MSTATUS, status_bits(1'b1, 1'b0));
    expect_csr(rv32_types::CSR_MSCRATCH, '0);
    value = $random(seed);
    modify_csr(rv32_types::CSR_OP_WRITE, rv32_types::CSR_MSCRATCH, value, '0);
    expect_csr(rv32_types::CSR_MSCRATCH, value);
    scratch_model = value;
    value = $random(seed);
    modify_csr(rv32_types::CSR_OP_WRITE, rv32_types::CSR_MTVEC, value, '0);
    expect_csr(rv32_types::CSR_MTVEC, value);
    mtvec_model = value;
endtask

task automatic read_modify_write();
    rv32_types::rv32_word      pick;
    rv32_types::rv32_word      operand;
    rv32_types::rv32_word      expected;
    rv32_types::csr_op_t       op;
    rv32_types::csr_response_t rsp;
    for (int i = 0; i < 12; i++) begin
        pick    = $random(seed);
        operand = $random(seed);
        // A zero operand now and then makes set and clear pure reads
        if (pick[1:0] == 2'b00) begin
            operand = '0;
        end
        case (pick[3:2])
            2'd0:    op = rv32_types::CSR_OP_WRITE;
            2'd1:    op = rv32_types::CSR_OP_SET;
            default: op = rv32_types::CSR_OP_CLEAR;
        endcase
        case (op)
            rv32_types::CSR_OP_WRITE: expected = operand;
            rv32_types::CSR_OP_SET:   expected = scratch_model | operand;
            default:                  expected = scratch_model & ~operand;
        endcase
        modify_csr(op, rv32_types::CSR_MSCRATCH, operand, scratch_model);
        scratch_model = expected;
    end
    expect_csr(rv32_types::CSR_MSCRATCH, scratch_model);

    // Only the defined bits survive
    modify_csr(rv32_types::CSR_OP_WRITE, rv32_types::CSR_MSTATUS, '1, status_bits(1'b1, 1'b0));
    expect_csr(rv32_types::CSR_MSTATUS, status_bits(1'b1, 1'b1));
    check_status("mstatus", mstatus, status_of(1'b1, 1'b1));
    modify_csr(rv32_types::CSR_OP_WRITE, rv32_types::CSR_MSTATUS, '0, status_bits(1'b1, 1'b1));
    modify_csr(rv32_types::CSR_OP_WRITE, rv32_types::CSR_MIE, '1, '0);
    expect_csr(rv32_types::CSR_MIE, enable_bits(1'b1, 1'b1, 1'b1));
    modify_csr(rv32_types::CSR_OP_WRITE, rv32_types::CSR_MIE, '0, enable_bits(1'b1, 1'b1, 1'b1));

    csr_access(rv32_types::CSR_OP_SET, UNIMPL_ADDR, '0, rsp);
    check_rsp("csr_rsp unimplemented read", rsp, rsp_of('0, 1'b1));
    csr_access(rv32_types::CSR_OP_WRITE, UNIMPL_ADDR, '1, rsp);
    check_rsp("csr_rsp unimplemented write", rsp, rsp_of('0, 1'b1));
endtask

task automatic counter_behavior();
    rv32_types::csr_addr_t     halves[4];
    rv32_types::rv32_word      words[4];
    rv32_types::csr_response_t rsp;
    rv32_types::rv32_word      first;
    rv32_types::rv32_word      tpc;
    logic [63:0]               instret;
    logic                      taken;
    halves = '{rv32_types::CSR_MCYCLE, rv32_types::CSR_MCYCLEH,
               rv32_types::CSR_MINSTRET, rv32_types::CSR_MINSTRETH};
    modify_csr(rv32_types::CSR_OP_WRITE, rv32_types::CSR_MCOUNTINHIBIT,
               inhibit_bits(1'b1, 1'b1), '0);
    expect_csr(rv32_types::CSR_MCOUNTINHIBIT, inhibit_bits(1'b1, 1'b1));
    for (int i = 0; i < 4; i++) begin
        words[i] = $random(seed);
        csr_access(rv32_types::CSR_OP_WRITE, halves[i], words[i], rsp);
        check_word("csr_rsp.strobe", 32'(rsp.strobe), 32'd1);
    end
    for (int i = 0; i < 4; i++) begin
        expect_csr(halves[i], words[i]);
    end

    // minstret counting while mcycle stays held
    instret = {words[3], words[2]};
    modify_csr(rv32_types::CSR_OP_WRITE, rv32_types::CSR_MCOUNTINHIBIT,
               inhibit_bits(1'b1, 1'b0), inhibit_bits(1'b1, 1'b1));
    for (int i = 0; i < RETIRE_COUNT; i++) begin
        do_retire($random(seed), taken, tpc);
        check_word("trap_taken", 32'(taken), 32'd0);
    end
    instret = instret + 64'(RETIRE_COUNT);
    expect_csr(rv32_types::CSR_MINSTRET, instret[31:0]);
    expect_csr(rv32_types::CSR_MINSTRETH, instret[63:32]);

    // Requests CYCLE_GAP edges apart
    modify_csr(rv32_types::CSR_OP_WRITE, rv32_types::CSR_MCOUNTINHIBIT, '0,
               inhibit_bits(1'b1, 1'b0));
    csr_access(rv32_types::CSR_OP_SET, rv32_types::CSR_MCYCLE, '0, rsp);
    first = rsp.data;
    repeat (CYCLE_GAP - 1) @(negedge clk);
    csr_access(rv32_types::CSR_OP_SET, rv32_types::CSR_MCYCLE, '0, rsp);
    check_word("mcycle difference", rsp.data - first, 32'(CYCLE_GAP));
endtask

task automatic take_interrupt(input rv32_types::irq_lines_t lines, input int unsigned code,
                              input logic mpie_before);
    rv32_types::rv32_word pc;
    rv32_types::rv32_word tpc;
    rv32_types::rv32_word cause;
    logic                 taken;
    pc = $random(seed);
    pc[1:0] = 2'b00;
    irq = lines;
    modify_csr(rv32_types::CSR_OP_SET, rv32_types::CSR_MSTATUS, status_bits(1'b0, 1'b1),
               status_bits(mpie_before, 1'b0));
    do_retire(pc, taken, tpc);
    check_word("trap_taken", 32'(taken), 32'd1);
    check_word("target_pc", tpc, {mtvec_model[31:2], 2'b00});
    check_status("mstatus", mstatus, status_of(1'b1, 1'b0));
    cause = code;
    cause[31] = 1'b1;
    expect_csr(rv32_types::CSR_MEPC, pc);
    expect_csr(rv32_types::CSR_MCAUSE, cause);
    expect_csr(rv32_types::CSR_MSTATUS, status_bits(1'b1, 1'b0));
    epc_model = pc;
endtask

task automatic trap_entry();
    rv32_types::rv32_word value;
    value = $random(seed);
    modify_csr(rv32_types::CSR_OP_WRITE, rv32_types::CSR_MTVEC, value, mtvec_model);
    mtvec_model = value;
    modify_csr(rv32_types::CSR_OP_WRITE, rv32_types::CSR_MIE, enable_bits(1'b1, 1'b1, 1'b1), '0);
    // Lines are external, timer, software from the top bit down
    take_interrupt(rv32_types::irq_lines_t'(3'b111), rv32_types::CAUSE_MEI, 1'b0);
    take_interrupt(rv32_types::irq_lines_t'(3'b011), rv32_types::CAUSE_MSI, 1'b1);
    take_interrupt(rv32_types::irq_lines_t'(3'b010), rv32_types::CAUSE_MTI, 1'b1);
endtask

task automatic masking_and_return();
    rv32_types::rv32_word tpc;
    logic                 flag;
    irq = rv32_types::irq_lines_t'(3'b100);
    modify_csr(rv32_types::CSR_OP_WRITE, rv32_types::CSR_MIE, enable_bits(1'b1, 1'b0, 1'b0),
               enable_bits(1'b1, 1'b1, 1'b1));
    modify_csr(rv32_types::CSR_OP_SET, rv32_types::CSR_MSTATUS, status_bits(1'b0, 1'b1),
               status_bits(1'b1, 1'b0));
    do_retire($random(seed), flag, tpc);
    check_word("trap_taken with meie clear", 32'(flag), 32'd0);
    modify_csr(rv32_types::CSR_OP_WRITE, rv32_types::CSR_MIE, enable_bits(1'b1, 1'b1, 1'b1),
               enable_bits(1'b1, 1'b0, 1'b0));
    modify_csr(rv32_types::CSR_OP_CLEAR, rv32_types::CSR_MSTATUS, status_bits(1'b0, 1'b1),
               status_bits(1'b1, 1'b1));
    do_retire($random(seed), flag, tpc);
    check_word("trap_taken with global mie clear", 32'(flag), 32'd0);
    expect_csr(rv32_types::CSR_MEPC, epc_model);
    irq = '0;

    do_mret(flag, tpc);
    check_word("mret_done", 32'(flag), 32'd1);
    check_word("trap_taken", 32'(trap_taken), 32'd0);
    check_word("target_pc", tpc, epc_model);
    check_status("mstatus", mstatus, status_of(1'b1, 1'b1));

    // With mpie clear the return leaves interrupts off
    modify_csr(rv32_types::CSR_OP_WRITE, rv32_types::CSR_MSTATUS, '0, status_bits(1'b1, 1'b1));
    do_mret(flag, tpc);
    check_word("mret_done", 32'(flag), 32'd1);
    check_status("mstatus", mstatus, status_of(1'b1, 1'b0));
endtask

// ==== testbench/tb_csr_unit.sv ====
// Testbench top for the CSR and trap unit with clock, reset, timeout and test sequence
`timescale 1ns/1ps

module tb_csr_unit;

    localparam int unsigned RESET_CYCLES = 4;
    localparam int unsigned CYCLE_GAP    = 8;
    localparam int unsigned RETIRE_COUNT = 5;
    localparam rv32_types::csr_addr_t UNIMPL_ADDR = rv32_types::csr_addr_t'(12'h7C0);

    // Rough length of each directed test in clock cycles
    localparam int unsigned PLAIN_CYCLES   = 10;
    localparam int unsigned RMW_CYCLES     = 30;
    localparam int unsigned COUNTER_CYCLES = 40;
    localparam int unsigned TRAP_CYCLES    = 25;
    localparam int unsigned RETURN_CYCLES  = 20;
    localparam int unsigned TIMEOUT_MARGIN = 50;
    localparam int unsigned TIMEOUT_CYCLES = RESET_CYCLES + PLAIN_CYCLES + RMW_CYCLES
                                             + COUNTER_CYCLES + TRAP_CYCLES + RETURN_CYCLES
                                             + TIMEOUT_MARGIN;

    logic                      clk;
    logic                      resetn;
    rv32_types::csr_request_t  csr_req;
    rv32_types::retire_t       retire;
    logic                      mret;
    rv32_types::irq_lines_t    irq;
    rv32_types::csr_response_t csr_rsp;
    logic                      trap_taken;
    logic                      mret_done;
    rv32_types::rv32_word      target_pc;
    rv32_types::mstatus_t      mstatus;

    int                   seed = 32'h11a7;
    int unsigned          checks_done;
    int unsigned          cycle_count = 0;

    // Expected register contents carried from one test to the next
    rv32_types::rv32_word scratch_model;
    rv32_types::rv32_word mtvec_model;
    rv32_types::rv32_word epc_model;

    csr_unit_top #(
        .COUNTER_WIDTH (64)
    ) csr_unit_top_i (
        .clk        (clk),
        .resetn     (resetn),
        .csr_req    (csr_req),
        .retire     (retire),
        .mret       (mret),
        .irq        (irq),
        .csr_rsp    (csr_rsp),
        .trap_taken (trap_taken),
        .mret_done  (mret_done),
        .target_pc  (target_pc),
        .mstatus    (mstatus)
    );

    `include "tb_csr_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            abort_run($sformatf("Timeout, tests still running after %0d cycles", cycle_count));
        end
    end

    initial begin
        checks_done = 0;
        resetn      = 1'b0;
        csr_req     = '0;
        retire      = '0;
        mret        = 1'b0;
        irq         = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;

        reset_and_plain_regs();
        read_modify_write();
        counter_behavior();
        trap_entry();
        masking_and_return();

        if (checks_done > 0) begin
            $display("All %0d checks matched", checks_done);
            $display("STATUS: PASS");
            $finish;
        end else begin
            abort_run("No checks were executed");
        end
    end

endmodule

// ==== sim.f ====
+incdir+testbench
src/rv32_types.sv
src/csr_rmw_unit.sv
src/csr_counters.sv
src/rv32_csr.sv
src/trap_controller.sv
src/csr_unit_top.sv
testbench/tb_csr_unit.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = tb_csr_unit
FILELIST  = sim.f
OBJ_DIR   = obj_dir
PASS_MSG  = STATUS: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(OBJ_DIR)
